/* list.f */
+incdir+testbench
source/rv_exec_pkg.sv
source/rv_decoder.sv
source/rv_regfile.sv
source/rv_exu.sv
source/rv_lsu.sv
source/rv_exec_core.sv
testbench/tb_rv_exec_core.sv

/* Makefile */
TOOL       = verilator
TOP        = tb_rv_exec_core
RTL_TOP    = rv_exec_core
FILELIST   = list.f
BUILD_DIR  = obj_dir
LOG        = sim.log
LINT_FLAGS = --lint-only --timing
SIM_FLAGS  = --binary --timing --assert -j 0 --Mdir $(BUILD_DIR)

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(TOOL) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^Simulation PASSED$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* testbench/tb_ref_model.svh */
// reference model of the rv64 execute subsystem, instruction encoders and random source
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// xorshift64, state lives in the testbench
function automatic logic [63:0] next_rand();
  rng_state = rng_state ^ (rng_state << 13);
  rng_state = rng_state ^ (rng_state >> 7);
  rng_state = rng_state ^ (rng_state << 17);
  return rng_state;
endfunction

function automatic logic [63:0] rand_pc();
  return next_rand() & ~64'd3;
endfunction

function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                       input logic [4:0] rs1, input logic [2:0] f3,
                                       input logic [4:0] rd, input logic [6:0] opc);
  return {f7, rs2, rs1, f3, rd, opc};
endfunction

function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                       input logic [2:0] f3, input logic [4:0] rd,
                                       input logic [6:0] opc);
  return {imm, rs1, f3, rd, opc};
endfunction

function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
                                       input logic [4:0] rs1, input logic [2:0] f3,
                                       input logic [6:0] opc);
  return {imm[11:5], rs2, rs1, f3, imm[4:0], opc};
endfunction

function automatic logic [31:0] b_type(input logic [12:0] imm, input logic [4:0] rs2,
                                       input logic [4:0] rs1, input logic [2:0] f3);
  return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
endfunction

function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd,
                                       input logic [6:0] opc);
  return {imm, rd, opc};
endfunction

function automatic logic [31:0] j_type(input logic [20:0] imm, input logic [4:0] rd);
  return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
endfunction

// one instruction against the model state, returns what writeback should report
function automatic wb_t model_step(input logic [31:0] instr, input logic [63:0] pc_in,
                                   ref logic [63:0] regs [32], ref logic [63:0] mem [256],
                                   ref logic halt_flag, ref logic illegal_flag);
  wb_t         w;
  logic [63:0] a, b, imm_i, imm_s, imm_b, imm_u, imm_j, addr, dw;
  logic [31:0] sum32;
  logic        taken;
  a     = regs[instr[19:15]];
  b     = regs[instr[24:20]];
  imm_i = 64'($signed(instr[31:20]));
  imm_s = 64'($signed({instr[31:25], instr[11:7]}));
  imm_b = 64'($signed({instr[31], instr[7], instr[30:25], instr[11:8], 1'b0}));
  imm_u = 64'($signed({instr[31:12], 12'b0}));
  imm_j = 64'($signed({instr[31], instr[19:12], instr[20], instr[30:21], 1'b0}));
  w         = '0;
  w.rd      = instr[11:7];
  w.next_pc = pc_in + 64'd4;
  taken     = 1'b0;
  case (instr[6:0])
    OPC_LUI: begin
      w.reg_wr = 1'b1;
      w.wdata  = imm_u;
    end
    OPC_AUIPC: begin
      w.reg_wr = 1'b1;
      w.wdata  = pc_in + imm_u;
    end
    OPC_JAL: begin
      w.reg_wr  = 1'b1;
      w.wdata   = pc_in + 64'd4;
      w.next_pc = pc_in + imm_j;
    end
    OPC_JALR: begin
      w.reg_wr  = 1'b1;
      w.wdata   = pc_in + 64'd4;
      w.next_pc = a + imm_i;  // no lsb clear here
    end
    OPC_BRANCH: begin
      case (instr[14:12])
        3'b000:  taken = (a == b);
        3'b001:  taken = (a != b);
        3'b100:  taken = ($signed(a) < $signed(b));
        default: taken = ($signed(a) >= $signed(b));
      endcase
      if (taken) w.next_pc = pc_in + imm_b;
    end
    OPC_LOAD: begin
      addr     = a + imm_i;
      dw       = mem[addr[10:3]] >> (8 * addr[2:0]);
      w.reg_wr = 1'b1;
      case (instr[14:12])
        3'b000:  w.wdata = 64'($signed(dw[7:0]));
        3'b001:  w.wdata = 64'($signed(dw[15:0]));
        3'b010:  w.wdata = 64'($signed(dw[31:0]));
        3'b100:  w.wdata = 64'(dw[7:0]);
        3'b101:  w.wdata = 64'(dw[15:0]);
        default: w.wdata = dw;
      endcase
    end
    OPC_STORE: begin
      addr              = a + imm_s;
      mem[addr[10:3]] = b;
    end
    OPC_OPIMM: begin
      w.reg_wr = 1'b1;
      w.wdata  = a + imm_i;
    end
    OPC_OPIMM32: begin
      sum32    = a[31:0] + imm_i[31:0];
      w.reg_wr = 1'b1;
      w.wdata  = 64'($signed(sum32));
    end
    OPC_OP: begin
      w.reg_wr = 1'b1;
      case ({instr[31:25], instr[14:12]})
        {7'h20, 3'b000}: w.wdata = a - b;
        {7'h00, 3'b011}: w.wdata = (a < b) ? 64'd1 : 64'd0;
        {7'h01, 3'b110}: begin
          if (b == 64'd0) w.wdata = a;  // remainder of divide by zero
          else if (b == {64{1'b1}}) w.wdata = 64'd0;
          else w.wdata = 64'($signed(a) % $signed(b));
        end
        default: w.wdata = a + b;
      endcase
    end
    OPC_OP32: begin
      sum32    = a[31:0] + b[31:0];
      w.reg_wr = 1'b1;
      w.wdata  = 64'($signed(sum32));
    end
    default: begin
      if (instr == 32'h0010_0073) halt_flag = 1'b1;
      else illegal_flag = 1'b1;
    end
  endcase
  if (w.reg_wr && w.rd != 5'd0) regs[w.rd] = w.wdata;
  return w;
endfunction

`endif

/* testbench/tb_rv_exec_core.sv */
// testbench for the rv64 execute subsystem, checks every writeback against a reference model
`timescale 1ns/10ps

module tb_rv_exec_core;
  import rv_exec_pkg::*;

  typedef struct packed {
    wb_t  wb;
    logic halt;
    logic illegal;
  } expect_t;

  localparam int N_SEED      = 16;  // auipc + addi for x1..x8
  localparam int N_ALU       = 15;
  localparam int N_WORD      = 8;
  localparam int N_MEM       = 58;
  localparam int N_BRANCH    = 20;
  localparam int N_FLAG      = 3;
  localparam int N_INSTS     = N_SEED + N_ALU + N_WORD + N_MEM + N_BRANCH + N_FLAG;
  localparam int WATCHDOG_NS = (4 + 3 * N_INSTS + 50) * 10;

  logic        clk;
  logic        arst_n;
  logic        issue;
  logic [31:0] inst;
  logic [63:0] pc;
  logic        wb_valid;
  wb_t         wb_out;
  logic        halt;
  logic        illegal;

  logic [63:0] rng_state = 64'd33048;
  logic [63:0] model_regs [32];
  logic [63:0] model_mem [256];
  logic        model_halt;
  logic        model_illegal;
  expect_t     exp_q [$];
  int          n_value_err;
  int          n_other_err;
  int          n_issued;
  int          n_checked;

  `include "tb_ref_model.svh"

  rv_exec_core #(
    .XLEN      (XLEN),
    .NREGS     (NREGS),
    .MEM_WORDS (MEM_WORDS)
  ) i_dut (
    .i_clk      (clk),
    .i_arst_n   (arst_n),
    .i_issue    (issue),
    .i_inst     (inst),
    .i_pc       (pc),
    .o_wb_valid (wb_valid),
    .o_wb       (wb_out),
    .o_halt     (halt),
    .o_illegal  (illegal)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic check_wb(input string name, input wb_t got, input wb_t exp);
    if (got.reg_wr !== exp.reg_wr) begin
      $display("** Error %s.reg_wr: got 0x%h, expected 0x%h", name, got.reg_wr, exp.reg_wr);
      n_value_err++;
    end
    if (got.next_pc !== exp.next_pc) begin
      $display("** Error %s.next_pc: got 0x%h, expected 0x%h", name, got.next_pc, exp.next_pc);
      n_value_err++;
    end
    if (exp.reg_wr) begin  // rd and data only matter on a write
      if (got.rd !== exp.rd) begin
        $display("** Error %s.rd: got 0x%h, expected 0x%h", name, got.rd, exp.rd);
        n_value_err++;
      end
      if (got.wdata !== exp.wdata) begin
        $display("** Error %s.wdata: got 0x%h, expected 0x%h", name, got.wdata, exp.wdata);
        n_value_err++;
      end
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("** Error %s: got 0x%h, expected 0x%h", name, got, exp);
      n_value_err++;
    end
  endtask

  // model first, then one issue cycle and two idle ones
  task automatic send_inst(input logic [31:0] instr, input logic [63:0] pc_in);
    expect_t e;
    e.wb      = model_step(instr, pc_in, model_regs, model_mem, model_halt, model_illegal);
    e.halt    = model_halt;
    e.illegal = model_illegal;
    exp_q.push_back(e);
    n_issued++;
    issue = 1'b1;
    inst  = instr;
    pc    = pc_in;
    @(posedge clk);
    #1;
    issue = 1'b0;
    repeat (2) @(posedge clk);
    #1;
  endtask

  initial begin : compare
    expect_t e;
    forever begin
      @(posedge clk);
      if (issue === 1'b1) begin
        #1;
        if (wb_valid !== 1'b0) begin
          $display("writeback strobe arrived one cycle early, at %0t", $time);
          n_other_err++;
        end
        @(posedge clk);
        #1;  // writeback cycle, outputs settled
        e = exp_q.pop_front();
        if (wb_valid !== 1'b1) begin
          $display("writeback strobe missing two cycles after the issue, at %0t", $time);
          n_other_err++;
        end else begin
          check_wb("o_wb", wb_out, e.wb);
        end
        check_flag("o_halt", halt, e.halt);
        check_flag("o_illegal", illegal, e.illegal);
        n_checked++;
        @(posedge clk);
        #1;
        if (wb_valid !== 1'b0) begin
          $display("writeback strobe lasted more than one cycle, at %0t", $time);
          n_other_err++;
        end
      end
    end
  end

  initial begin : watchdog
    #(WATCHDOG_NS);
    $display("run did not finish within %0d ns, %0d of %0d instructions checked",
             WATCHDOG_NS, n_checked, N_INSTS);
    $display("Simulation FAILED");
    $finish;
  end

  initial begin : stimulus
    logic [63:0] r;
    logic [31:0] word;
    logic [4:0]  rd, rs1, rs2;
    logic [2:0]  f3;
    arst_n        = 1'b0;
    issue         = 1'b0;
    inst          = '0;
    pc            = '0;
    model_halt    = 1'b0;
    model_illegal = 1'b0;
    n_value_err   = 0;
    n_other_err   = 0;
    n_issued      = 0;
    n_checked     = 0;
    for (int i = 0; i < 32; i++) model_regs[i] = '0;
    for (int i = 0; i < 256; i++) model_mem[i] = '0;
    repeat (3) @(posedge clk);
    #1;
    arst_n = 1'b1;
    @(posedge clk);
    #1;

    // random pcs make auipc give full 64-bit seeds
    for (int k = 1; k <= 8; k++) begin
      r = next_rand();
      send_inst(u_type(r[19:0], 5'(k), OPC_AUIPC), rand_pc());
      send_inst(i_type(r[31:20], 5'(k), 3'b000, 5'(k), OPC_OPIMM), rand_pc());
    end

    for (int k = 0; k < 12; k++) begin
      r   = next_rand();
      rd  = 5'(r[3:0]);
      rs1 = 5'(1 + r[6:4]);
      rs2 = 5'(1 + r[9:7]);
      case (r[11:10])
        2'd0: word = r_type(7'h00, rs2, rs1, 3'b000, rd, OPC_OP);  // add
        2'd1: word = r_type(7'h20, rs2, rs1, 3'b000, rd, OPC_OP);  // sub
        2'd2: word = r_type(7'h00, rs2, rs1, 3'b011, rd, OPC_OP);  // sltu
        2'd3: word = r_type(7'h01, rs2, rs1, 3'b110, rd, OPC_OP);  // rem
      endcase
      send_inst(word, rand_pc());
    end
    send_inst(r_type(7'h00, 5'd2, 5'd1, 3'b000, 5'd0, OPC_OP), rand_pc());   // write to x0
    send_inst(r_type(7'h00, 5'd0, 5'd0, 3'b000, 5'd9, OPC_OP), rand_pc());   // x0 still zero
    send_inst(r_type(7'h01, 5'd0, 5'd1, 3'b110, 5'd10, OPC_OP), rand_pc());  // rem by zero

    for (int k = 0; k < 4; k++) begin
      r   = next_rand();
      rd  = 5'(11 + k);
      rs1 = 5'(1 + r[2:0]);
      rs2 = 5'(1 + r[5:3]);
      send_inst(i_type(r[17:6], rs1, 3'b000, rd, OPC_OPIMM32), rand_pc());
      send_inst(r_type(7'h00, rs2, rs1, 3'b000, rd, OPC_OP32), rand_pc());
    end

    for (int k = 0; k < 2; k++) begin
      r = next_rand();
      send_inst(i_type({1'b0, r[10:3], 3'b000}, 5'd0, 3'b000, 5'd20, OPC_OPIMM), rand_pc());
      send_inst(s_type(12'd0, 5'(1 + r[13:11]), 5'd20, 3'b011, OPC_STORE), rand_pc());
      for (int off = 0; off < 8; off++) begin
        send_inst(i_type(12'(off), 5'd20, 3'b000, 5'd21, OPC_LOAD), rand_pc());  // lb
        send_inst(i_type(12'(off), 5'd20, 3'b100, 5'd22, OPC_LOAD), rand_pc());  // lbu
        if (off % 2 == 0) begin
          send_inst(i_type(12'(off), 5'd20, 3'b001, 5'd23, OPC_LOAD), rand_pc());
          send_inst(i_type(12'(off), 5'd20, 3'b101, 5'd24, OPC_LOAD), rand_pc());
        end
        if (off % 4 == 0) send_inst(i_type(12'(off), 5'd20, 3'b010, 5'd21, OPC_LOAD), rand_pc());
        if (off == 0) send_inst(i_type(12'd0, 5'd20, 3'b011, 5'd22, OPC_LOAD), rand_pc());
      end
    end

    // equal pair plus both orders of a different pair
    for (int k = 0; k < 4; k++) begin
      f3 = (k < 2) ? 3'(k) : 3'(k + 2);
      r  = next_rand();
      send_inst(b_type({r[11:0], 1'b0}, 5'd1, 5'd1, f3), rand_pc());
      send_inst(b_type({r[23:12], 1'b0}, 5'd2, 5'd1, f3), rand_pc());
      send_inst(b_type({r[35:24], 1'b0}, 5'd1, 5'd2, f3), rand_pc());
    end
    for (int k = 0; k < 2; k++) begin
      r = next_rand();
      send_inst(j_type({r[20:1], 1'b0}, 5'd25), rand_pc());
      send_inst(i_type(r[32:21], 5'(1 + k), 3'b000, 5'd26, OPC_JALR), rand_pc());
      send_inst(u_type(r[52:33], 5'd27, OPC_LUI), rand_pc());
      send_inst(u_type(r[63:44], 5'd28, OPC_AUIPC), rand_pc());
    end

    send_inst(32'hffff_ffff, rand_pc());  // opcode 7f undefined
    send_inst(32'h0010_0073, rand_pc());  // ebreak
    send_inst(i_type(12'd5, 5'd0, 3'b000, 5'd29, OPC_OPIMM), rand_pc());
    @(posedge clk);  // let the last strobe drop
    #1;

    if (n_checked != n_issued) begin
      $display("only %0d of %0d issued instructions reached a check", n_checked, n_issued);
      n_other_err++;
    end
    $display("errors: %0d value mismatches, %0d other failures, %0d instructions checked",
             n_value_err, n_other_err, n_checked);
    if (n_value_err == 0 && n_other_err == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

/* source/rv_exec_core.sv */
// rv64 execute subsystem top: decoder, register file, execute unit and lsu
`timescale 1ns/10ps

module rv_exec_core #(
  parameter int XLEN      = rv_exec_pkg::XLEN,
  parameter int NREGS     = rv_exec_pkg::NREGS,
  parameter int MEM_WORDS = rv_exec_pkg::MEM_WORDS
) (
  input  logic              i_clk,
  input  logic              i_arst_n,
  input  logic              i_issue,
  input  logic [31:0]       i_inst,
  input  logic [XLEN-1:0]   i_pc,
  output logic              o_wb_valid,
  output rv_exec_pkg::wb_t  o_wb,
  output logic              o_halt,
  output logic              o_illegal
);
  import rv_exec_pkg::*;

  logic            dec_valid;
  ctrl_t           dec_ctrl;
  logic [XLEN-1:0] rs1_data;
  logic [XLEN-1:0] rs2_data;
  logic            ex_valid;
  ex_t             ex;
  logic [XLEN-1:0] mem_addr;
  logic [XLEN-1:0] mem_wdata;
  logic            mem_we;

  rv_decoder #(
    .XLEN (XLEN)
  ) u_decoder (
    .i_clk    (i_clk),
    .i_arst_n (i_arst_n),
    .i_issue  (i_issue),
    .i_inst   (i_inst),
    .i_pc     (i_pc),
    .o_valid  (dec_valid),
    .o_ctrl   (dec_ctrl)
  );

  rv_regfile #(
    .XLEN  (XLEN),
    .NREGS (NREGS)
  ) u_regfile (
    .i_clk      (i_clk),
    .i_arst_n   (i_arst_n),
    .i_rs1      (dec_ctrl.rs1),
    .i_rs2      (dec_ctrl.rs2),
    .o_rs1_data (rs1_data),
    .o_rs2_data (rs2_data),
    .i_we       (o_wb_valid & o_wb.reg_wr),  // writeback closes the loop
    .i_rd       (o_wb.rd),
    .i_wdata    (o_wb.wdata)
  );

  rv_exu #(
    .XLEN (XLEN)
  ) u_exu (
    .i_clk       (i_clk),
    .i_arst_n    (i_arst_n),
    .i_valid     (dec_valid),
    .i_ctrl      (dec_ctrl),
    .i_rs1_data  (rs1_data),
    .i_rs2_data  (rs2_data),
    .o_valid     (ex_valid),
    .o_ex        (ex),
    .o_mem_addr  (mem_addr),
    .o_mem_wdata (mem_wdata),
    .o_mem_we    (mem_we),
    .o_halt      (o_halt),
    .o_illegal   (o_illegal)
  );

  rv_lsu #(
    .XLEN      (XLEN),
    .MEM_WORDS (MEM_WORDS)
  ) u_lsu (
    .i_clk       (i_clk),
    .i_mem_addr  (mem_addr),
    .i_mem_wdata (mem_wdata),
    .i_mem_we    (mem_we),
    .i_valid     (ex_valid),
    .i_ex        (ex),
    .o_wb_valid  (o_wb_valid),
    .o_wb        (o_wb)
  );

endmodule

/* source/rv_lsu.sv */
// load/store unit: doubleword data ram, load extension and writeback select
`timescale 1ns/10ps

module rv_lsu #(
  parameter int XLEN      = rv_exec_pkg::XLEN,
  parameter int MEM_WORDS = rv_exec_pkg::MEM_WORDS
) (
  input  logic              i_clk,
  input  logic [XLEN-1:0]   i_mem_addr,
  input  logic [XLEN-1:0]   i_mem_wdata,
  input  logic              i_mem_we,
  input  logic              i_valid,
  input  rv_exec_pkg::ex_t  i_ex,
  output logic              o_wb_valid,
  output rv_exec_pkg::wb_t  o_wb
);
  import rv_exec_pkg::*;

  localparam int AW = $clog2(MEM_WORDS);

  logic [XLEN-1:0] mem [MEM_WORDS];
  logic [AW-1:0]   idx;
  logic [XLEN-1:0] rdata_q, lane, load_data;
  logic            misaligned;

  assign idx = i_mem_addr[AW+2:3];  // doubleword index

  always_ff @(posedge i_clk) begin
    if (i_mem_we) mem[idx] <= i_mem_wdata;
    rdata_q <= mem[idx];
  end

  assign lane = rdata_q >> {i_ex.addr_off, 3'b000};

  always_comb begin
    case (i_ex.mem_op)
      MEM_LB:  load_data = {{(XLEN-8){lane[7]}}, lane[7:0]};
      MEM_LBU: load_data = {{(XLEN-8){1'b0}}, lane[7:0]};
      MEM_LH:  load_data = {{(XLEN-16){lane[15]}}, lane[15:0]};
      MEM_LHU: load_data = {{(XLEN-16){1'b0}}, lane[15:0]};
      MEM_LW:  load_data = {{(XLEN-32){lane[31]}}, lane[31:0]};
      default: load_data = rdata_q;
    endcase
  end

  always_comb begin
    o_wb.rd      = i_ex.rd;
    o_wb.reg_wr  = i_ex.reg_wr;
    o_wb.wdata   = i_ex.mem_to_reg ? load_data : i_ex.alu_result;
    o_wb.next_pc = i_ex.next_pc;
  end

  assign o_wb_valid = i_valid;

  assign misaligned = (i_ex.mem_op inside {MEM_LH, MEM_LHU} && i_ex.addr_off[0])   ||
                      (i_ex.mem_op == MEM_LW && i_ex.addr_off[1:0] != 2'b00)      ||
                      (i_ex.mem_op == MEM_LD && i_ex.addr_off != 3'b000);

  a_load_aligned: assert property (@(posedge i_clk)
    i_valid && i_ex.mem_to_reg |-> !misaligned);

endmodule

/* source/rv_exu.sv */
// execute unit: operand select, alu, branch decision and next pc, output registered
`timescale 1ns/10ps

module rv_exu #(
  parameter int XLEN = rv_exec_pkg::XLEN
) (
  input  logic                i_clk,
  input  logic                i_arst_n,
  input  logic                i_valid,
  input  rv_exec_pkg::ctrl_t  i_ctrl,
  input  logic [XLEN-1:0]     i_rs1_data,
  input  logic [XLEN-1:0]     i_rs2_data,
  output logic                o_valid,
  output rv_exec_pkg::ex_t    o_ex,
  output logic [XLEN-1:0]     o_mem_addr,
  output logic [XLEN-1:0]     o_mem_wdata,
  output logic                o_mem_we,
  output logic                o_halt,
  output logic                o_illegal
);
  import rv_exec_pkg::*;

  logic [XLEN-1:0] src1, src2, imm;
  logic [XLEN-1:0] src_a, src_b;
  logic [XLEN-1:0] add_res, sub_res, rem_res, alu_raw, alu_res;
  logic            zero, less;
  logic            pc_imm, pc_rs1;  // next pc adder selects
  ex_t             ex_d;
  logic            valid_q, halt_q, illegal_q;

  // word ops see only the low halves
  assign src1 = i_ctrl.word_cut ? {{(XLEN-32){1'b0}}, i_rs1_data[31:0]} : i_rs1_data;
  assign src2 = i_ctrl.word_cut ? {{(XLEN-32){1'b0}}, i_rs2_data[31:0]} : i_rs2_data;
  assign imm  = i_ctrl.word_cut ? {{(XLEN-32){1'b0}}, i_ctrl.imm[31:0]} : i_ctrl.imm;

  assign src_a = (i_ctrl.a_src == A_PC) ? i_ctrl.pc : src1;

  always_comb begin
    case (i_ctrl.b_src)
      B_RS2:   src_b = src2;
      B_IMM:   src_b = imm;
      default: src_b = XLEN'(4);
    endcase
  end

  assign add_res = src_a + src_b;
  assign sub_res = src_a - src_b;

  // divide by zero and overflow follow the isa
  always_comb begin
    if (src_b == '0) begin
      rem_res = src_a;
    end else if (&src_b) begin
      rem_res = '0;  // x % -1
    end else begin
      rem_res = $signed(src_a) % $signed(src_b);
    end
  end

  always_comb begin
    case (i_ctrl.alu_op)
      ALU_SUB:  alu_raw = sub_res;
      ALU_SLTU: alu_raw = {{(XLEN-1){1'b0}}, src_a < src_b};
      ALU_REM:  alu_raw = rem_res;
      ALU_COPY: alu_raw = i_ctrl.imm;
      default:  alu_raw = add_res;
    endcase
  end

  assign alu_res = i_ctrl.word_cut ? {{(XLEN-32){alu_raw[31]}}, alu_raw[31:0]} : alu_raw;

  assign zero = ~(|alu_res);
  // sign of the difference, corrected when the operand signs differ
  assign less = (src_a[XLEN-1] ^ src_b[XLEN-1]) ? src_a[XLEN-1] : alu_res[XLEN-1];

  always_comb begin
    case (i_ctrl.branch)
      BR_JAL, BR_JALR: pc_imm = 1'b1;
      BR_BEQ:          pc_imm = zero;
      BR_BNE:          pc_imm = ~zero;
      BR_BLT:          pc_imm = less;
      BR_BGE:          pc_imm = ~less;
      default:         pc_imm = 1'b0;
    endcase
  end

  assign pc_rs1 = (i_ctrl.branch == BR_JALR);

  always_comb begin
    ex_d            = '0;
    ex_d.alu_result = alu_res;
    ex_d.next_pc    = (pc_rs1 ? i_rs1_data : i_ctrl.pc) + (pc_imm ? i_ctrl.imm : XLEN'(4));
    ex_d.rd         = i_ctrl.rd;
    ex_d.reg_wr     = i_ctrl.reg_wr;
    ex_d.mem_to_reg = i_ctrl.mem_to_reg;
    ex_d.mem_op     = i_ctrl.mem_op;
    ex_d.addr_off   = alu_res[2:0];
  end

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      valid_q   <= 1'b0;
      halt_q    <= 1'b0;
      illegal_q <= 1'b0;
    end else begin
      valid_q <= i_valid;
      if (i_valid && i_ctrl.ebreak) halt_q <= 1'b1;
      if (i_valid && i_ctrl.illegal) illegal_q <= 1'b1;
    end
  end

  always_ff @(posedge i_clk) begin
    o_ex <= ex_d;
  end

  // ram sees the address this cycle, write and read launch on the next edge
  assign o_mem_addr  = alu_res;
  assign o_mem_wdata = i_rs2_data;
  assign o_mem_we    = i_valid & i_ctrl.mem_wr;

  assign o_valid   = valid_q;
  assign o_halt    = halt_q;
  assign o_illegal = illegal_q;

  a_wr_excl: assert property (@(posedge i_clk) disable iff (!i_arst_n)
    i_valid |-> !(i_ctrl.mem_wr && i_ctrl.reg_wr));

endmodule

/* source/rv_regfile.sv */
// integer register file with two asynchronous reads and one clocked write
`timescale 1ns/10ps

module rv_regfile #(
  parameter int XLEN  = rv_exec_pkg::XLEN,
  parameter int NREGS = rv_exec_pkg::NREGS
) (
  input  logic            i_clk,
  input  logic            i_arst_n,
  input  logic [4:0]      i_rs1,
  input  logic [4:0]      i_rs2,
  output logic [XLEN-1:0] o_rs1_data,
  output logic [XLEN-1:0] o_rs2_data,
  input  logic            i_we,
  input  logic [4:0]      i_rd,
  input  logic [XLEN-1:0] i_wdata
);

  logic [XLEN-1:0] regs [NREGS];

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      for (int i = 0; i < NREGS; i++) begin
        regs[i] <= '0;
      end
    end else if (i_we && i_rd != 5'd0) begin  // x0 is hardwired
      regs[i_rd] <= i_wdata;
    end
  end

  assign o_rs1_data = (i_rs1 == 5'd0) ? '0 : regs[i_rs1];
  assign o_rs2_data = (i_rs2 == 5'd0) ? '0 : regs[i_rs2];

endmodule

/* source/rv_decoder.sv */
// rv64 decoder: latches the issued instruction and produces the control word
`timescale 1ns/10ps

module rv_decoder #(
  parameter int XLEN = rv_exec_pkg::XLEN
) (
  input  logic                i_clk,
  input  logic                i_arst_n,
  input  logic                i_issue,
  input  logic [31:0]         i_inst,
  input  logic [XLEN-1:0]     i_pc,
  output logic                o_valid,
  output rv_exec_pkg::ctrl_t  o_ctrl
);
  import rv_exec_pkg::*;

  logic [31:0]     inst_q;
  logic [XLEN-1:0] pc_q;
  logic            valid_q;
  logic [6:0]      opcode;
  logic [2:0]      funct3;
  logic [6:0]      funct7;
  logic [XLEN-1:0] imm_i, imm_s, imm_b, imm_u, imm_j;

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= i_issue;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_issue) begin
      inst_q <= i_inst;
      pc_q   <= i_pc;
    end
  end

  assign opcode = inst_q[6:0];
  assign funct3 = inst_q[14:12];
  assign funct7 = inst_q[31:25];

  assign imm_i = {{(XLEN-12){inst_q[31]}}, inst_q[31:20]};
  assign imm_s = {{(XLEN-12){inst_q[31]}}, inst_q[31:25], inst_q[11:7]};
  assign imm_b = {{(XLEN-13){inst_q[31]}}, inst_q[31], inst_q[7], inst_q[30:25],
                  inst_q[11:8], 1'b0};
  assign imm_u = {{(XLEN-32){inst_q[31]}}, inst_q[31:12], 12'b0};
  assign imm_j = {{(XLEN-21){inst_q[31]}}, inst_q[31], inst_q[19:12], inst_q[20],
                  inst_q[30:21], 1'b0};

  always_comb begin
    o_ctrl         = '0;
    o_ctrl.rd      = inst_q[11:7];
    o_ctrl.rs1     = inst_q[19:15];
    o_ctrl.rs2     = inst_q[24:20];
    o_ctrl.pc      = pc_q;
    o_ctrl.imm     = imm_i;
    o_ctrl.illegal = 1'b1;  // cleared by every known encoding
    case (opcode)
      OPC_LUI: begin
        o_ctrl.alu_op  = ALU_COPY;
        o_ctrl.imm     = imm_u;
        o_ctrl.reg_wr  = 1'b1;
        o_ctrl.illegal = 1'b0;
      end
      OPC_AUIPC: begin
        o_ctrl.a_src   = A_PC;
        o_ctrl.b_src   = B_IMM;
        o_ctrl.imm     = imm_u;
        o_ctrl.reg_wr  = 1'b1;
        o_ctrl.illegal = 1'b0;
      end
      OPC_JAL, OPC_JALR: begin
        // link value is pc + 4 from the alu
        o_ctrl.a_src  = A_PC;
        o_ctrl.b_src  = B_FOUR;
        o_ctrl.branch = (opcode == OPC_JAL) ? BR_JAL : BR_JALR;
        o_ctrl.imm    = (opcode == OPC_JAL) ? imm_j : imm_i;
        if (opcode == OPC_JAL || funct3 == 3'b000) begin
          o_ctrl.reg_wr  = 1'b1;
          o_ctrl.illegal = 1'b0;
        end
      end
      OPC_BRANCH: begin
        o_ctrl.alu_op = ALU_SUB;
        o_ctrl.imm    = imm_b;
        if (funct3 inside {3'b000, 3'b001, 3'b100, 3'b101}) begin
          o_ctrl.branch  = branch_e'({1'b1, funct3[2], funct3[0]});
          o_ctrl.illegal = 1'b0;
        end
      end
      OPC_LOAD: begin
        o_ctrl.b_src      = B_IMM;
        o_ctrl.mem_to_reg = 1'b1;
        o_ctrl.illegal    = 1'b0;
        o_ctrl.reg_wr     = 1'b1;
        case (funct3)
          3'b000:  o_ctrl.mem_op = MEM_LB;
          3'b001:  o_ctrl.mem_op = MEM_LH;
          3'b010:  o_ctrl.mem_op = MEM_LW;
          3'b011:  o_ctrl.mem_op = MEM_LD;
          3'b100:  o_ctrl.mem_op = MEM_LBU;
          3'b101:  o_ctrl.mem_op = MEM_LHU;
          default: begin
            o_ctrl.illegal = 1'b1;
            o_ctrl.reg_wr  = 1'b0;
          end
        endcase
      end
      OPC_STORE: begin
        o_ctrl.b_src = B_IMM;
        o_ctrl.imm   = imm_s;
        if (funct3 == 3'b011) begin  // sd only
          o_ctrl.mem_wr  = 1'b1;
          o_ctrl.illegal = 1'b0;
        end
      end
      OPC_OPIMM, OPC_OPIMM32: begin
        o_ctrl.b_src    = B_IMM;
        o_ctrl.word_cut = (opcode == OPC_OPIMM32);
        if (funct3 == 3'b000) begin
          o_ctrl.reg_wr  = 1'b1;
          o_ctrl.illegal = 1'b0;
        end
      end
      OPC_OP, OPC_OP32: begin
        o_ctrl.word_cut = (opcode == OPC_OP32);
        o_ctrl.illegal  = 1'b0;
        o_ctrl.reg_wr   = 1'b1;
        case ({opcode == OPC_OP32, funct7, funct3})
          {1'b0, 7'b0000000, 3'b000}: o_ctrl.alu_op = ALU_ADD;
          {1'b0, 7'b0100000, 3'b000}: o_ctrl.alu_op = ALU_SUB;
          {1'b0, 7'b0000000, 3'b011}: o_ctrl.alu_op = ALU_SLTU;
          {1'b0, 7'b0000001, 3'b110}: o_ctrl.alu_op = ALU_REM;
          {1'b1, 7'b0000000, 3'b000}: o_ctrl.alu_op = ALU_ADD;  // addw
          default: begin
            o_ctrl.illegal = 1'b1;
            o_ctrl.reg_wr  = 1'b0;
          end
        endcase
      end
      default: begin
        if (inst_q == INST_EBREAK) begin
          o_ctrl.ebreak  = 1'b1;
          o_ctrl.illegal = 1'b0;
        end
      end
    endcase
  end

  assign o_valid = valid_q;

  // no forwarding, so back-to-back issues would read stale registers
  a_issue_spacing: assert property (@(posedge i_clk) disable iff (!i_arst_n)
    i_issue |=> !i_issue ##1 !i_issue);

endmodule

/* source/rv_exec_pkg.sv */
// rv64 execute subsystem package with opcodes, control encodings and stage structs
package rv_exec_pkg;

  // defaults for the top-level parameters
  localparam int XLEN      = 64;
  localparam int NREGS     = 32;
  localparam int MEM_WORDS = 256;

  localparam logic [6:0] OPC_LUI     = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC   = 7'b0010111;
  localparam logic [6:0] OPC_JAL     = 7'b1101111;
  localparam logic [6:0] OPC_JALR    = 7'b1100111;
  localparam logic [6:0] OPC_BRANCH  = 7'b1100011;
  localparam logic [6:0] OPC_LOAD    = 7'b0000011;
  localparam logic [6:0] OPC_STORE   = 7'b0100011;
  localparam logic [6:0] OPC_OPIMM   = 7'b0010011;
  localparam logic [6:0] OPC_OPIMM32 = 7'b0011011;
  localparam logic [6:0] OPC_OP      = 7'b0110011;
  localparam logic [6:0] OPC_OP32    = 7'b0111011;

  localparam logic [31:0] INST_EBREAK = 32'h0010_0073;

  typedef enum logic [2:0] {
    ALU_ADD  = 3'd0,
    ALU_SUB  = 3'd1,
    ALU_SLTU = 3'd2,
    ALU_REM  = 3'd3,
    ALU_COPY = 3'd4  // pass immediate through
  } alu_op_e;

  typedef enum logic {
    A_RS1 = 1'b0,
    A_PC  = 1'b1
  } a_src_e;

  typedef enum logic [1:0] {
    B_RS2  = 2'b00,
    B_IMM  = 2'b01,
    B_FOUR = 2'b10
  } b_src_e;

  typedef enum logic [2:0] {
    BR_NONE = 3'b000,
    BR_JAL  = 3'b001,
    BR_JALR = 3'b010,
    BR_BEQ  = 3'b100,
    BR_BNE  = 3'b101,
    BR_BLT  = 3'b110,
    BR_BGE  = 3'b111
  } branch_e;

  typedef enum logic [2:0] {
    MEM_LB  = 3'b000,
    MEM_LBU = 3'b001,
    MEM_LH  = 3'b010,
    MEM_LHU = 3'b011,
    MEM_LW  = 3'b100,
    MEM_LD  = 3'b110
  } mem_op_e;

  typedef struct packed {
    alu_op_e         alu_op;
    a_src_e          a_src;
    b_src_e          b_src;
    branch_e         branch;
    mem_op_e         mem_op;
    logic            word_cut;
    logic            mem_to_reg;
    logic            mem_wr;
    logic            reg_wr;
    logic [4:0]      rd;
    logic [4:0]      rs1;
    logic [4:0]      rs2;
    logic [XLEN-1:0] imm;
    logic [XLEN-1:0] pc;
    logic            ebreak;
    logic            illegal;
  } ctrl_t;

  typedef struct packed {
    logic [XLEN-1:0] alu_result;
    logic [XLEN-1:0] next_pc;
    logic [4:0]      rd;
    logic            reg_wr;
    logic            mem_to_reg;
    mem_op_e         mem_op;
    logic [2:0]      addr_off;  // byte within the doubleword
  } ex_t;

  typedef struct packed {
    logic [4:0]      rd;
    logic            reg_wr;
    logic [XLEN-1:0] wdata;
    logic [XLEN-1:0] next_pc;
  } wb_t;

endpackage
